// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module stepper_core_tb \
  && ./obj_dir/Vstepper_core_tb | tee /dev/stderr | grep -q "Test completed successfully" \
  && echo "Simulation passed" \
  || { echo "Simulation did not pass"; exit 1; }

// File: source/coil_drive_pkg.sv
package coil_drive_pkg;

  // How one H-bridge is driven
  typedef enum logic [1:0] {
    COIL_OFF = 2'd0,
    COIL_FWD = 2'd1,
    COIL_REV = 2'd2,
    COIL_BRAKE = 2'd3
  } coil_drive_t;

  // Full-step phase index
  typedef logic [1:0] phase_t;

endpackage

// File: source/command_decoder.sv
`timescale 1ns/1ns
`include "stepper_consts.svh"

module command_decoder import stepper_cmd_pkg::*; (
  input  logic                     CLK,
  input  logic                     resetn,
  input  logic [`WORD_BITS-1:0]    word,
  input  logic                     word_valid,
  input  logic                     cs_n_sync,
  output logic                     enable,
  output logic [`TARGET_BITS-1:0]  target_a,
  output logic [`TARGET_BITS-1:0]  target_b,
  output logic                     move_start,
  output logic                     move_dir,
  output logic [`COUNT_BITS-1:0]   move_count,
  output logic                     cmd_error
);

  dec_state_t state;
  opcode_t    opcode;

  assign opcode = opcode_t'(word[63:56]);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state <= DEC_HEADER;
      enable <= 1'b0;
      target_a <= '0;
      target_b <= '0;
      move_start <= 1'b0;
      move_dir <= 1'b0;
      move_count <= '0;
      cmd_error <= 1'b0;
    end else begin
      move_start <= 1'b0;
      cmd_error <= 1'b0;
      if (cs_n_sync) begin
        state <= DEC_HEADER;  // Frame ended
      end else if (word_valid) begin
        case (state)
          DEC_HEADER: begin
            case (opcode)
              OPC_ENABLE: enable <= word[0];
              OPC_CURRENT: begin
                target_a <= word[11:0];
                target_b <= word[27:16];
              end
              OPC_MOVE: begin
                move_dir <= word[0];
                state <= DEC_COUNT;  // Count follows
              end
              default: cmd_error <= 1'b1;
            endcase
          end
          DEC_COUNT: begin
            move_count <= word[`COUNT_BITS-1:0];
            move_start <= 1'b1;
            state <= DEC_HEADER;
          end
          default: state <= DEC_HEADER;
        endcase
      end
    end
  end

endmodule

// File: source/current_chopper.sv
`timescale 1ns/1ns
`include "stepper_consts.svh"

module current_chopper import coil_drive_pkg::*; (
  input  logic                            CLK,
  input  logic                            resetn,
  input  logic                            enable,
  input  phase_t                          phase,
  input  logic signed [`CUR_BITS-1:0]     current_a,
  input  logic signed [`CUR_BITS-1:0]     current_b,
  input  logic        [`TARGET_BITS-1:0]  target_a,
  input  logic        [`TARGET_BITS-1:0]  target_b,
  output logic                            cmp_a,
  output logic                            cmp_b,
  output logic [3:0]                      gate_a,
  output logic [3:0]                      gate_b
);

  coil_drive_t drive_a;
  coil_drive_t drive_b;

  // Magnitude as 12 unsigned bits
  function automatic logic [`TARGET_BITS-1:0] mag(input logic signed [`CUR_BITS-1:0] cur);
    logic [`CUR_BITS-1:0] abs_val;
    abs_val = cur[`CUR_BITS-1] ? -cur : cur;
    return abs_val[`TARGET_BITS-1:0];
  endfunction

  // high1, low1, high2, low2
  function automatic logic [3:0] gates(input coil_drive_t drv);
    case (drv)
      COIL_FWD: return 4'b1001;
      COIL_REV: return 4'b0110;
      COIL_BRAKE: return 4'b0101;
      default: return 4'b0000;
    endcase
  endfunction

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      cmp_a <= 1'b1;  // Brake until a target is set
      cmp_b <= 1'b1;
    end else begin
      cmp_a <= mag(current_a) >= target_a;
      cmp_b <= mag(current_b) >= target_b;
    end
  end

  always_comb begin
    drive_a = (phase == 2'd1 || phase == 2'd2) ? COIL_REV : COIL_FWD;
    drive_b = phase[1] ? COIL_REV : COIL_FWD;
    if (cmp_a) drive_a = COIL_BRAKE;
    if (cmp_b) drive_b = COIL_BRAKE;
    if (!enable) begin
      drive_a = COIL_OFF;
      drive_b = COIL_OFF;
    end
  end

  assign gate_a = gates(drive_a);
  assign gate_b = gates(drive_b);

endmodule

// File: source/spi_word_rx.sv
`timescale 1ns/1ns
`include "stepper_consts.svh"

module spi_word_rx (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic                   sck,
  input  logic                   cs_n,
  input  logic                   copi,
  output logic [`WORD_BITS-1:0]  word,
  output logic                   word_valid,
  output logic                   cs_n_sync
);

  localparam int BYTE_W = $clog2(`WORD_BITS / 8);

  logic [2:0]        pin_meta;  // sck, cs_n, copi
  logic [2:0]        pin_sync;
  logic              sck_prev;
  logic              sck_rise;
  logic [7:0]        byte_sr;
  logic [2:0]        bit_cnt;
  logic [BYTE_W-1:0] byte_cnt;
  logic [7:0]        byte_next;

  assign cs_n_sync = pin_sync[1];
  assign sck_rise = pin_sync[2] & ~sck_prev;
  assign byte_next = {byte_sr[6:0], pin_sync[0]};

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      pin_meta <= 3'b010;  // Deselected
      pin_sync <= 3'b010;
      sck_prev <= 1'b0;
    end else begin
      pin_meta <= {sck, cs_n, copi};
      pin_sync <= pin_meta;
      sck_prev <= pin_sync[2];
    end
  end

  always_ff @(posedge CLK) begin
    if (sck_rise && !cs_n_sync) begin
      byte_sr <= byte_next;
      if (bit_cnt == 3'd7) begin
        word[byte_cnt*8 +: 8] <= byte_next;  // Lowest byte first
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt <= '0;
      byte_cnt <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      if (cs_n_sync) begin
        bit_cnt <= '0;  // Drop any partial word
        byte_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          byte_cnt <= byte_cnt + 1'b1;
          if (byte_cnt == BYTE_W'(`WORD_BITS / 8 - 1)) begin
            word_valid <= 1'b1;
          end
        end
      end
    end
  end

endmodule

// File: source/step_sequencer.sv
`timescale 1ns/1ns
`include "stepper_consts.svh"

module step_sequencer import coil_drive_pkg::*; (
  input  logic                    CLK,
  input  logic                    resetn,
  input  logic                    enable,
  input  logic                    move_start,
  input  logic                    move_dir,
  input  logic [`COUNT_BITS-1:0]  move_count,
  output logic                    step,
  output logic                    dir,
  output logic                    busy,
  output logic                    move_done,
  output phase_t                  phase
);

  localparam int PERIOD_W = $clog2(`STEP_PERIOD);

  logic [`COUNT_BITS-1:0] remaining;
  logic [PERIOD_W-1:0]    period_cnt;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      step <= 1'b0;
      dir <= 1'b0;
      busy <= 1'b0;
      move_done <= 1'b0;
      phase <= '0;
      remaining <= '0;
      period_cnt <= '0;
    end else begin
      step <= 1'b0;
      move_done <= 1'b0;
      if (!enable) begin
        busy <= 1'b0;  // Abort, no done
      end else if (!busy) begin
        if (move_start) begin
          busy <= 1'b1;
          dir <= move_dir;
          remaining <= move_count;
          period_cnt <= '0;
        end
      end else if (remaining == '0) begin
        busy <= 1'b0;
        move_done <= 1'b1;
      end else if (period_cnt == PERIOD_W'(`STEP_PERIOD - 1)) begin
        period_cnt <= '0;
        step <= 1'b1;
        remaining <= remaining - 1'b1;
        if (dir) begin
          phase <= phase + 2'd1;
        end else begin
          phase <= phase - 2'd1;  // Wraps 0 to 3
        end
      end else begin
        period_cnt <= period_cnt + 1'b1;
      end
    end
  end

endmodule

// File: source/stepper_cmd_pkg.sv
`include "stepper_consts.svh"

package stepper_cmd_pkg;

  // Opcodes carried in a header word
  typedef enum logic [7:0] {
    OPC_MOVE = `OP_MOVE,
    OPC_ENABLE = `OP_ENABLE,
    OPC_CURRENT = `OP_CURRENT
  } opcode_t;

  // Decoder expects either a header or the count word of a move
  typedef enum logic [0:0] {
    DEC_HEADER = 1'b0,
    DEC_COUNT = 1'b1
  } dec_state_t;

endpackage

// File: source/stepper_consts.svh
`ifndef STEPPER_CONSTS_SVH
`define STEPPER_CONSTS_SVH

// SPI command word
`define WORD_BITS 64

// Coil current widths
`define CUR_BITS 13
`define TARGET_BITS 12

// Move parameters
`define COUNT_BITS 24
`define STEP_PERIOD 16

// Header opcodes, found in word bits 63 to 56
`define OP_ENABLE 8'h0a
`define OP_MOVE 8'h01
`define OP_CURRENT 8'h0b

`endif

// File: source/stepper_core.sv
`timescale 1ns/1ns
`include "stepper_consts.svh"

module stepper_core import coil_drive_pkg::*; (
  input  logic                         CLK,
  input  logic                         resetn,
  input  logic                         sck,
  input  logic                         cs_n,
  input  logic                         copi,
  input  logic signed [`CUR_BITS-1:0]  current_a,
  input  logic signed [`CUR_BITS-1:0]  current_b,
  output logic                         step,
  output logic                         dir,
  output logic                         busy,
  output logic                         move_done,
  output logic                         cmd_error,
  output logic                         cmp_a,
  output logic                         cmp_b,
  output logic [3:0]                   gate_a,
  output logic [3:0]                   gate_b
);

  logic [`WORD_BITS-1:0]   word;
  logic                    word_valid;
  logic                    cs_n_sync;
  logic                    enable;
  logic [`TARGET_BITS-1:0] target_a;
  logic [`TARGET_BITS-1:0] target_b;
  logic                    move_start;
  logic                    move_dir;
  logic [`COUNT_BITS-1:0]  move_count;
  phase_t                  phase;

  spi_word_rx spi_rx0 (
    .CLK(CLK), .resetn(resetn), .sck(sck), .cs_n(cs_n), .copi(copi),
    .word(word), .word_valid(word_valid), .cs_n_sync(cs_n_sync)
  );

  command_decoder decoder0 (
    .CLK(CLK), .resetn(resetn), .word(word), .word_valid(word_valid),
    .cs_n_sync(cs_n_sync), .enable(enable), .target_a(target_a), .target_b(target_b),
    .move_start(move_start), .move_dir(move_dir), .move_count(move_count),
    .cmd_error(cmd_error)
  );

  step_sequencer sequencer0 (
    .CLK(CLK), .resetn(resetn), .enable(enable), .move_start(move_start),
    .move_dir(move_dir), .move_count(move_count), .step(step), .dir(dir),
    .busy(busy), .move_done(move_done), .phase(phase)
  );

  current_chopper chopper0 (
    .CLK(CLK), .resetn(resetn), .enable(enable), .phase(phase),
    .current_a(current_a), .current_b(current_b), .target_a(target_a),
    .target_b(target_b), .cmp_a(cmp_a), .cmp_b(cmp_b), .gate_a(gate_a), .gate_b(gate_b)
  );

endmodule

// File: tb/stepper_core_checker.sv
`timescale 1ns/1ns
`include "stepper_consts.svh"

module stepper_core_checker import stepper_cmd_pkg::*, coil_drive_pkg::*; (
  input logic       CLK,
  input logic       resetn,
  input logic       step,
  input logic       dir,
  input logic       move_done,
  input logic       cmd_error,
  input logic       cmp_a,
  input logic       cmp_b,
  input logic [3:0] gate_a,
  input logic [3:0] gate_b
);

  localparam logic [3:0] REV_A = 4'b0110;  // Phases 1 and 2
  localparam logic [3:0] REV_B = 4'b1100;  // Phases 2 and 3

  int n_steps = 0;
  int n_dones = 0;
  int n_errs = 0;
  int n_errors = 0;

  always @(negedge CLK) begin
    if (resetn) begin
      if (step) n_steps++;
      if (move_done) n_dones++;
      if (cmd_error) n_errs++;
    end
  end

  function automatic coil_drive_t expect_drive(input bit en, input bit cmp, input bit rev);
    if (!en) return COIL_OFF;
    if (cmp) return COIL_BRAKE;
    return rev ? COIL_REV : COIL_FWD;
  endfunction

  // {high1, low1, high2, low2}
  function automatic logic [3:0] pattern(input coil_drive_t d);
    case (d)
      COIL_FWD: return {1'b1, 1'b0, 1'b0, 1'b1};
      COIL_REV: return {1'b0, 1'b1, 1'b1, 1'b0};
      COIL_BRAKE: return {1'b0, 1'b1, 1'b0, 1'b1};
      default: return 4'b0000;
    endcase
  endfunction

  task automatic expect_eq(input string name, input string what, input logic [31:0] exp,
                           input logic [31:0] act);
    if (act !== exp) begin
      n_errors++;
      $display("[ERROR] %s %s: expected %0h, actual %0h", name, what, exp, act);
    end
  endtask

  task automatic check_entry(input string name, input int exp_steps, input int exp_dones,
                             input int exp_errs, input bit en, input int ph, input bit dr,
                             input bit ca, input bit cb);
    expect_eq(name, "steps", exp_steps, n_steps);
    expect_eq(name, "move_done", exp_dones, n_dones);
    expect_eq(name, "cmd_error", exp_errs, n_errs);
    expect_eq(name, "dir", dr, dir);
    expect_eq(name, "cmp_a", ca, cmp_a);
    expect_eq(name, "cmp_b", cb, cmp_b);
    expect_eq(name, "gate_a", pattern(expect_drive(en, ca, REV_A[ph])), gate_a);
    expect_eq(name, "gate_b", pattern(expect_drive(en, cb, REV_B[ph])), gate_b);
    n_steps = 0;
    n_dones = 0;
    n_errs = 0;
  endtask

endmodule

// File: tb/stepper_core_sva.sv
`timescale 1ns/1ns

module stepper_core_sva (
  input logic       CLK,
  input logic       resetn,
  input logic       step,
  input logic       busy,
  input logic       move_done,
  input logic [3:0] gate_a,
  input logic [3:0] gate_b
);

  // Gate order high1, low1, high2, low2
  no_shoot_a: assert property (@(posedge CLK) disable iff (!resetn)
    !(gate_a[3] && gate_a[2]) && !(gate_a[1] && gate_a[0]))
    else $error("gate_a drives high and low on one side");

  no_shoot_b: assert property (@(posedge CLK) disable iff (!resetn)
    !(gate_b[3] && gate_b[2]) && !(gate_b[1] && gate_b[0]))
    else $error("gate_b drives high and low on one side");

  step_in_move: assert property (@(posedge CLK) disable iff (!resetn) step |-> busy)
    else $error("step pulse outside a move");

  quiet_at_start: assert property (@(posedge CLK) disable iff (!resetn)
    $rose(busy) |-> !move_done && !step)
    else $error("step or move_done as busy rises");

endmodule

bind stepper_core stepper_core_sva sva0 (.*);

// File: tb/stepper_core_tb.sv
`timescale 1ns/1ns
`include "stepper_consts.svh"

module stepper_core_tb import stepper_cmd_pkg::*, coil_drive_pkg::*; ();

  localparam logic [`TARGET_BITS-1:0] TGT_A = 12'h800;
  localparam logic [`TARGET_BITS-1:0] TGT_B = 12'h600;
  localparam logic signed [`CUR_BITS-1:0] QUIET_A = 13'sd300;
  localparam logic signed [`CUR_BITS-1:0] QUIET_B = -13'sd500;

  typedef struct packed {
    logic [1:0]  nw;
    logic [63:0] w0;
    logic [63:0] w1;
    logic        rnd;
    logic [7:0]  steps;
    logic [1:0]  dones;
    logic [1:0]  errs;
    logic        en;
    logic [1:0]  ph;
    logic        dr;
    logic        chk;
  } entry_t;

  logic CLK = 1'b0;
  logic resetn;
  logic sck;
  logic cs_n;
  logic copi;
  logic signed [`CUR_BITS-1:0] current_a;
  logic signed [`CUR_BITS-1:0] current_b;
  logic step, dir, busy, move_done, cmd_error, cmp_a, cmp_b;
  logic [3:0] gate_a;
  logic [3:0] gate_b;
  logic [23:0] lfsr = 24'd82749;
  string names[$];
  entry_t table_q[$];

  always #10 CLK = ~CLK;

  stepper_core dut0 (.*);

  stepper_core_checker chk0 (
    .CLK(CLK), .resetn(resetn), .step(step), .dir(dir), .move_done(move_done),
    .cmd_error(cmd_error), .cmp_a(cmp_a), .cmp_b(cmp_b), .gate_a(gate_a), .gate_b(gate_b)
  );

  // Taps 24, 23, 22, 17
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[23] ^ lfsr[22] ^ lfsr[21] ^ lfsr[16];
    lfsr = {lfsr[22:0], fb};
    return fb;
  endfunction

  function automatic logic signed [`CUR_BITS-1:0] draw_current();
    logic [`CUR_BITS-1:0] v;
    v = '0;
    for (int i = 0; i < `CUR_BITS; i++) v = {v[`CUR_BITS-2:0], lfsr_bit()};
    return v;
  endfunction

  function automatic bit at_target(input logic signed [`CUR_BITS-1:0] cur,
                                   input logic [`TARGET_BITS-1:0] tgt);
    int mag;
    mag = (cur < 0) ? -int'(cur) : int'(cur);
    return (mag % 4096) >= tgt;  // Magnitude kept to 12 bits
  endfunction

  function automatic logic [63:0] cmd(input logic [7:0] op, input logic [31:0] low);
    return {op, 24'h0, low};
  endfunction

  task automatic add(input string name, input int nw, input logic [63:0] w0,
                     input logic [63:0] w1, input bit rnd, input int steps, input int dones,
                     input int errs, input bit en, input int ph, input bit dr, input bit chk);
    entry_t e;
    e = '{nw[1:0], w0, w1, rnd, steps[7:0], dones[1:0], errs[1:0], en, ph[1:0], dr, chk};
    names.push_back(name);
    table_q.push_back(e);
  endtask

  // Mode 0, 4 clocks low then 4 high
  task automatic send_bit(input logic b);
    @(posedge CLK);
    sck <= 1'b0;
    copi <= b;
    repeat (4) @(posedge CLK);
    sck <= 1'b1;
    repeat (3) @(posedge CLK);
  endtask

  task automatic send_word(input logic [63:0] w);
    for (int i = 0; i < 8; i++) begin  // Low byte first
      for (int j = 7; j >= 0; j--) send_bit(w[i*8+j]);
    end
  endtask

  task automatic send_frame(input int nw, input logic [63:0] w0, input logic [63:0] w1);
    @(posedge CLK);
    cs_n <= 1'b0;
    send_word(w0);
    if (nw > 1) send_word(w1);
    @(posedge CLK);
    sck <= 1'b0;
    cs_n <= 1'b1;
  endtask

  task automatic run_entry(input int i);
    entry_t e;
    logic signed [`CUR_BITS-1:0] ca;
    logic signed [`CUR_BITS-1:0] cb;
    e = table_q[i];
    ca = e.rnd ? draw_current() : QUIET_A;
    cb = e.rnd ? draw_current() : QUIET_B;
    @(posedge CLK);
    current_a <= ca;
    current_b <= cb;
    if (e.nw != 0) send_frame(e.nw, e.w0, e.w1);
    if (e.chk) begin
      repeat (8) @(posedge CLK);  // Sync and decoder latency
      @(negedge CLK);
      while (busy) @(negedge CLK);
      @(posedge CLK);
      @(negedge CLK);
      chk0.check_entry(names[i], e.steps, e.dones, e.errs, e.en, e.ph, e.dr,
                       at_target(ca, TGT_A), at_target(cb, TGT_B));
    end
  endtask

  initial begin
    // name, words, w0, w1, random current, steps, done, error, enable, phase, dir, check
    add("set_current", 1, cmd(OPC_CURRENT, {4'h0, TGT_B, 4'h0, TGT_A}), 0,
        0, 0, 0, 0, 0, 0, 0, 1);
    add("enable_on", 1, cmd(OPC_ENABLE, 1), 0, 0, 0, 0, 0, 1, 0, 0, 1);
    add("move_up_5", 2, cmd(OPC_MOVE, 1), 5, 0, 5, 1, 0, 1, 1, 1, 1);
    add("move_down_7", 2, cmd(OPC_MOVE, 0), 7, 0, 7, 1, 0, 1, 2, 0, 1);
    add("bad_opcode", 1, {8'h55, 56'h0}, 0, 0, 0, 0, 1, 1, 2, 0, 1);
    add("zero_count", 2, cmd(OPC_MOVE, 1), 0, 0, 0, 1, 0, 1, 2, 1, 1);
    for (int i = 0; i < 4; i++) add("chop_random", 0, 0, 0, 1, 0, 0, 0, 1, 2, 1, 1);
    add("long_move", 2, cmd(OPC_MOVE, 1), 100, 0, 0, 0, 0, 1, 2, 1, 0);
    add("move_while_busy", 2, cmd(OPC_MOVE, 0), 3, 0, 100, 1, 0, 1, 2, 1, 1);
    add("enable_off", 1, cmd(OPC_ENABLE, 0), 0, 0, 0, 0, 0, 0, 2, 1, 1);
    add("move_disabled", 2, cmd(OPC_MOVE, 0), 4, 0, 0, 0, 0, 0, 2, 1, 1);
    resetn = 1'b0;
    sck = 1'b0;
    cs_n = 1'b1;
    copi = 1'b0;
    current_a = QUIET_A;
    current_b = QUIET_B;
    repeat (8) @(posedge CLK);
    resetn <= 1'b1;
    foreach (table_q[i]) run_entry(i);
    $display("Entries run: %0d, mismatches: %0d", names.size(), chk0.n_errors);
    if (chk0.n_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin : watchdog
    longint budget;
    budget = 0;
    #1;
    foreach (table_q[i]) begin
      budget += table_q[i].nw * `WORD_BITS * 8 + table_q[i].steps * `STEP_PERIOD;
    end
    #(budget * 2 * 20);  // Twice the test length, 20 ns per clock
    $display("Timeout: the DUT did not finish the tests in time");
    $display("Test failed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+source
source/stepper_cmd_pkg.sv
source/coil_drive_pkg.sv
source/spi_word_rx.sv
source/command_decoder.sv
source/step_sequencer.sv
source/current_chopper.sv
source/stepper_core.sv
tb/stepper_core_sva.sv
tb/stepper_core_checker.sv
tb/stepper_core_tb.sv
